//--- logic/opp_data_pkg.sv
`default_nettype none

package opp_data_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int SAMPLE_W = 18;	// default internal width, error samples
	localparam int OUT_W    = 16;	// default output width, DAC/DDS word

	////////////////////
	// sequencer
	////////////////////

	// one sample in flight, so four states are enough
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,	// waiting for a sample
		ST_COMPUTE = 2'd1,	// datapath settling
		ST_SEND    = 2'd2,	// result offered downstream
		ST_DONE    = 2'd3	// store previous output
	} opp_state_t;

	////////////////////
	// datapath strobes
	////////////////////

	typedef struct packed {
		logic capture;		// load sample and lock enable
		logic latch_prev;	// store clamped result as previous
		logic out_valid;	// result handed to consumer
	} opp_ctrl_t;

endpackage

`default_nettype wire

//--- logic/opp_regs_pkg.sv
`default_nettype none

package opp_regs_pkg;

	////////////////////
	// APB request
	////////////////////

	typedef struct packed {
		logic        psel;		// slave selected
		logic        penable;	// access phase
		logic        pwrite;	// 1 = write
		logic [4:0]  paddr;		// byte address, word aligned
		logic [31:0] pwdata;	// write data
	} apb_req_t;

	////////////////////
	// register map
	////////////////////

	localparam logic [4:0] ADDR_OUT_MAX  = 5'h00;	// upper bound, output scale
	localparam logic [4:0] ADDR_OUT_MIN  = 5'h04;	// lower bound, output scale
	localparam logic [4:0] ADDR_OUT_INIT = 5'h08;	// start value, output scale
	localparam logic [4:0] ADDR_MULT     = 5'h0C;	// gain, unsigned
	localparam logic [4:0] ADDR_CTRL     = 5'h10;	// bit 0 update enable
	localparam logic [4:0] ADDR_UPDATE   = 5'h14;	// write only strobe

	// front-panel parameter set, fields sized at output scale
	typedef struct packed {
		logic signed [opp_data_pkg::OUT_W-1:0] out_max;		// upper bound
		logic signed [opp_data_pkg::OUT_W-1:0] out_min;		// lower bound
		logic signed [opp_data_pkg::OUT_W-1:0] out_init;	// value while unlocked
		logic        [7:0]                     mult;		// error gain
	} opp_params_t;

endpackage

`default_nettype wire

//--- logic/opp_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module opp_apb_regs #(
	parameter int OMAX_INIT = 26214,	// active upper bound after reset
	parameter int OMIN_INIT = 6553,		// active lower bound after reset
	parameter int OUT_INIT  = 19660,	// active init value after reset
	parameter int MULT_INIT = 1			// active gain after reset
) (
	input wire                         clk_in,
	input wire                         reset_in,
	input wire opp_regs_pkg::apb_req_t apb_req,
	output logic [31:0]                prdata,
	output logic                       pready,
	output logic                       pslverr,
	output opp_regs_pkg::opp_params_t  params,	// active set
	output logic                       reload	// shadow copied this edge
);
	import opp_data_pkg::*;
	import opp_regs_pkg::*;

	localparam opp_params_t PARAMS_RST = '{
		out_max:  OUT_W'(OMAX_INIT),
		out_min:  OUT_W'(OMIN_INIT),
		out_init: OUT_W'(OUT_INIT),
		mult:     8'(MULT_INIT)
	};

	opp_params_t shadow;	// written over APB
	logic        update_en;	// CTRL bit 0
	logic        access;	// access phase of any transfer
	logic        wr_en;		// access phase of a write
	logic        addr_hit;	// address is mapped

	////////////////////
	// APB decode
	////////////////////

	assign access = apb_req.psel & apb_req.penable;
	assign wr_en  = access & apb_req.pwrite;
	assign pready = 1'b1;	// no wait states

	always_comb begin
		addr_hit = 1'b1;
		prdata   = '0;
		case (apb_req.paddr)
			ADDR_OUT_MAX:  prdata = 32'(shadow.out_max);	// sign extended
			ADDR_OUT_MIN:  prdata = 32'(shadow.out_min);
			ADDR_OUT_INIT: prdata = 32'(shadow.out_init);
			ADDR_MULT:     prdata = 32'(shadow.mult);		// zero extended
			ADDR_CTRL:     prdata = {31'd0, update_en};
			ADDR_UPDATE:   prdata = '0;	// strobe, nothing stored
			default:       addr_hit = 1'b0;
		endcase
	end

	// reading the strobe register is an error as well
	assign pslverr = access & (~addr_hit | (~apb_req.pwrite & (apb_req.paddr == ADDR_UPDATE)));
	assign reload  = wr_en & (apb_req.paddr == ADDR_UPDATE) & update_en;

	////////////////////
	// shadow and active
	////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			shadow    <= PARAMS_RST;
			params    <= PARAMS_RST;
			update_en <= 1'b0;	// updates locked out until enabled
		end else begin
			if (wr_en) begin
				case (apb_req.paddr)
					ADDR_OUT_MAX:  shadow.out_max  <= apb_req.pwdata[OUT_W-1:0];
					ADDR_OUT_MIN:  shadow.out_min  <= apb_req.pwdata[OUT_W-1:0];
					ADDR_OUT_INIT: shadow.out_init <= apb_req.pwdata[OUT_W-1:0];
					ADDR_MULT:     shadow.mult     <= apb_req.pwdata[7:0];
					ADDR_CTRL:     update_en       <= apb_req.pwdata[0];
					default:       ;	// strobe and unmapped hold nothing
				endcase
			end
			if (reload) begin
				params <= shadow;	// whole set at once
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/opp_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module opp_sequencer (
	input wire                      clk_in,
	input wire                      reset_in,
	input wire                      sample_valid,
	output logic                    sample_ready,
	output logic                    timer_start,	// compute phase begins
	input wire                      timer_done,		// last compute cycle
	output opp_data_pkg::opp_ctrl_t ctrl
);
	import opp_data_pkg::*;

	opp_state_t state;		// current state
	opp_state_t state_nxt;	// next state
	logic       accept;		// sample taken this edge

	assign sample_ready = (state == ST_IDLE);	// busy otherwise, offers dropped
	assign accept       = sample_valid & sample_ready;
	assign timer_start  = accept;

	////////////////////
	// strobes
	////////////////////

	assign ctrl.capture    = accept;
	assign ctrl.out_valid  = (state == ST_SEND);	// one cycle only
	assign ctrl.latch_prev = (state == ST_DONE);	// stored on the way back to idle

	////////////////////
	// state machine
	////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (accept) state_nxt = ST_COMPUTE;
			end
			ST_COMPUTE: begin
				if (timer_done) state_nxt = ST_SEND;	// latency counted elsewhere
			end
			ST_SEND: state_nxt = ST_DONE;
			ST_DONE: state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

`default_nettype wire

//--- logic/opp_latency_timer.sv
`timescale 1ns/1ps
`default_nettype none

module opp_latency_timer #(
	parameter int COMP_LATENCY = 3	// compute cycles, at least 1
) (
	input wire   clk_in,
	input wire   reset_in,
	input wire   start,	// loads on the capture edge
	output logic done	// high in the last compute cycle
);
	localparam int CW = (COMP_LATENCY > 1) ? $clog2(COMP_LATENCY) : 1;

	logic [CW-1:0] count;	// cycles left after this one
	logic          running;

	assign done = running & (count == '0);

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			count   <= '0;
			running <= 1'b0;
		end else if (start) begin
			count   <= CW'(COMP_LATENCY - 1);
			running <= 1'b1;
		end else if (done) begin
			running <= 1'b0;	// one expiry per start
		end else if (running) begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/opp_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module opp_accumulator #(
	parameter int W_IN     = 18,	// internal width
	parameter int W_OUT    = 16,	// output width
	parameter int OUT_INIT = 19660	// start value, output scale
) (
	input wire                            clk_in,
	input wire                            reset_in,
	input wire logic signed [W_IN-1:0]    sample_data,
	input wire                            lock_en,
	input wire opp_data_pkg::opp_ctrl_t   ctrl,
	input wire opp_regs_pkg::opp_params_t params,	// active set
	input wire                            reload,
	output logic signed [W_IN-1:0]        acc_sum,	// gain times error plus previous
	output logic                          lock_held,	// lock enable of this sample
	input wire logic signed [W_IN-1:0]    prev_in	// clamped result
);
	localparam int SHIFT = W_IN - W_OUT;	// output to internal scale
	localparam logic signed [W_IN-1:0] S_MAX    = {1'b0, {(W_IN-1){1'b1}}};
	localparam logic signed [W_IN-1:0] S_MIN    = {1'b1, {(W_IN-1){1'b0}}};
	localparam logic signed [W_IN-1:0] PREV_RST = W_IN'(OUT_INIT) <<< SHIFT;

	logic signed [W_IN-1:0] sample_q;		// captured error
	logic signed [W_IN-1:0] prev_q;			// previous output, full precision
	logic                   reload_q;		// new init is active one edge after the copy
	logic signed [W_IN-1:0] init_int;		// active init, internal scale
	logic signed [W_IN+8:0] product;		// full precision product
	logic                   mul_ovf;
	logic signed [W_IN-1:0] product_sat;
	logic signed [W_IN:0]   sum_full;		// one guard bit
	logic                   add_ovf;

	assign init_int = W_IN'(params.out_init) <<< SHIFT;

	////////////////////
	// multiply, saturate
	////////////////////

	assign product     = sample_q * $signed({1'b0, params.mult});	// gain is unsigned
	assign mul_ovf     = product[W_IN+8:W_IN-1] != {10{product[W_IN+8]}};
	assign product_sat = mul_ovf ? (product[W_IN+8] ? S_MIN : S_MAX) : product[W_IN-1:0];

	////////////////////
	// add, saturate
	////////////////////

	assign sum_full = product_sat + prev_q;
	assign add_ovf  = sum_full[W_IN] != sum_full[W_IN-1];	// sign flipped
	assign acc_sum  = add_ovf ? (sum_full[W_IN] ? S_MIN : S_MAX) : sum_full[W_IN-1:0];

	always_ff @(posedge clk_in) begin
		if (ctrl.capture) begin
			sample_q <= sample_data;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			lock_held <= 1'b0;
			reload_q  <= 1'b0;
			prev_q    <= PREV_RST;
		end else begin
			reload_q <= reload;
			if (ctrl.capture) begin
				lock_held <= lock_en;
			end
			if (reload_q) begin
				prev_q <= init_int;	// restart from the new init
			end else if (ctrl.latch_prev) begin
				prev_q <= prev_in;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/opp_output_clamp.sv
`timescale 1ns/1ps
`default_nettype none

module opp_output_clamp #(
	parameter int W_IN  = 18,	// internal width
	parameter int W_OUT = 16	// output width
) (
	input wire logic signed [W_IN-1:0]    acc_sum,
	input wire                            lock_held,
	input wire opp_regs_pkg::opp_params_t params,
	input wire opp_data_pkg::opp_ctrl_t   ctrl,
	output logic signed [W_IN-1:0]        clamped,	// fed back as previous output
	output logic signed [W_OUT-1:0]       out_data,
	output logic                          out_valid
);
	localparam int SHIFT = W_IN - W_OUT;	// bounds arrive at output scale

	logic signed [W_IN-1:0] max_int;
	logic signed [W_IN-1:0] min_int;
	logic signed [W_IN-1:0] init_int;
	logic signed [W_IN-1:0] selected;	// locked sum or fixed init
	logic signed [W_IN-1:0] upper;		// after the upper bound

	assign max_int  = W_IN'(params.out_max) <<< SHIFT;
	assign min_int  = W_IN'(params.out_min) <<< SHIFT;
	assign init_int = W_IN'(params.out_init) <<< SHIFT;

	assign selected = lock_held ? acc_sum : init_int;
	assign upper    = (selected > max_int) ? max_int : selected;
	assign clamped  = (upper < min_int) ? min_int : upper;	// crossed bounds give min

	assign out_data  = clamped[W_IN-1 -: W_OUT];	// drop the extra LSBs
	assign out_valid = ctrl.out_valid;

endmodule

`default_nettype wire

//--- logic/output_preprocessor.sv
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor #(
	parameter int W_IN         = opp_data_pkg::SAMPLE_W,	// internal width
	parameter int W_OUT        = opp_data_pkg::OUT_W,		// output width, front-panel fields
	parameter int COMP_LATENCY = 3,							// compute cycles
	parameter int OMAX_INIT    = 26214,
	parameter int OMIN_INIT    = 6553,
	parameter int OUT_INIT     = 19660,
	parameter int MULT_INIT    = 1
) (
	input wire                         clk_in,
	input wire                         reset_in,
	input wire opp_regs_pkg::apb_req_t apb_req,
	output logic [31:0]                prdata,
	output logic                       pready,
	output logic                       pslverr,
	input wire logic signed [W_IN-1:0] sample_data,	// from the multiplexer
	input wire                         sample_valid,
	output logic                       sample_ready,
	input wire                         lock_en,
	output logic signed [W_OUT-1:0]    out_data,	// to the DAC/DDS
	output logic                       out_valid
);
	import opp_data_pkg::*;
	import opp_regs_pkg::*;

	opp_params_t            params;			// active set
	opp_ctrl_t              ctrl;
	logic                   reload;
	logic                   timer_start;
	logic                   timer_done;
	logic                   lock_held;
	logic signed [W_IN-1:0] acc_sum;
	logic signed [W_IN-1:0] clamped;		// loops back into the accumulator

	opp_apb_regs #(
		.OMAX_INIT(OMAX_INIT), .OMIN_INIT(OMIN_INIT), .OUT_INIT(OUT_INIT), .MULT_INIT(MULT_INIT)
	) u_regs (
		.clk_in(clk_in), .reset_in(reset_in), .apb_req(apb_req), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .params(params), .reload(reload)
	);

	opp_sequencer u_seq (
		.clk_in(clk_in), .reset_in(reset_in), .sample_valid(sample_valid),
		.sample_ready(sample_ready), .timer_start(timer_start), .timer_done(timer_done),
		.ctrl(ctrl)
	);

	opp_latency_timer #(.COMP_LATENCY(COMP_LATENCY)) u_timer (
		.clk_in(clk_in), .reset_in(reset_in), .start(timer_start), .done(timer_done)
	);

	opp_accumulator #(.W_IN(W_IN), .W_OUT(W_OUT), .OUT_INIT(OUT_INIT)) u_acc (
		.clk_in(clk_in), .reset_in(reset_in), .sample_data(sample_data), .lock_en(lock_en),
		.ctrl(ctrl), .params(params), .reload(reload), .acc_sum(acc_sum),
		.lock_held(lock_held), .prev_in(clamped)
	);

	opp_output_clamp #(.W_IN(W_IN), .W_OUT(W_OUT)) u_clamp (
		.acc_sum(acc_sum), .lock_held(lock_held), .params(params), .ctrl(ctrl),
		.clamped(clamped), .out_data(out_data), .out_valid(out_valid)
	);

endmodule

`default_nettype wire

//--- test/opp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module opp_tb;
	import opp_regs_pkg::*;

	localparam int COMP_LATENCY = 3;	// DUT default
	localparam int RESET_CYCLES = 16;
	localparam STIM_FILE = "test/opp_stimulus.txt";

	logic               clk_in;
	logic               reset_in;
	apb_req_t           apb_req;
	logic [31:0]        prdata;
	logic               pready;
	logic               pslverr;
	logic signed [17:0] sample_data;	// W_IN wide
	logic               sample_valid;
	logic               sample_ready;
	logic               lock_en;
	logic signed [15:0] out_data;	// W_OUT wide
	logic               out_valid;

	logic [31:0]     rng_state;	// xorshift state
	int              checks;
	int              errors;
	int              tests;
	int              test_checks;	// counts when the current test began
	int              test_errors;
	int              line_count;	// sizes the watchdog
	logic [8*32-1:0] test_name;

	output_preprocessor dut (
		.clk_in(clk_in), .reset_in(reset_in), .apb_req(apb_req), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .sample_data(sample_data),
		.sample_valid(sample_valid), .sample_ready(sample_ready), .lock_en(lock_en),
		.out_data(out_data), .out_valid(out_valid)
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;	// 10 ns period
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic addr_mapped(input logic [4:0] addr);
		case (addr)
			ADDR_OUT_MAX, ADDR_OUT_MIN, ADDR_OUT_INIT,
			ADDR_MULT, ADDR_CTRL, ADDR_UPDATE: addr_mapped = 1'b1;
			default: addr_mapped = 1'b0;	// holes give pslverr
		endcase
	endfunction

	task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
		begin
			checks++;
			assert (got === exp) else begin
				$display("CHECK FAILED %0s got 0x%h expected 0x%h at %0t", sig, got, exp, $time);
				errors++;
			end
		end
	endtask

	task automatic finish_test();
		begin
			tests++;
			$display("test %0s: %0d checks, %0d errors", test_name,
				checks - test_checks, errors - test_errors);
		end
	endtask

	// two-cycle transfer, pready never drops
	task automatic apb_transfer(input logic write, input logic [4:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp_rdata, input logic exp_err);
		begin
			@(posedge clk_in);
			#1;
			apb_req.psel    = 1'b1;	// setup
			apb_req.penable = 1'b0;
			apb_req.pwrite  = write;
			apb_req.paddr   = addr;
			apb_req.pwdata  = wdata;
			#1;
			check_value("pslverr", pslverr, 1'b0);	// only in access
			@(posedge clk_in);
			#1;
			apb_req.penable = 1'b1;	// access
			#1;
			check_value("pready", pready, 1'b1);
			check_value("pslverr", pslverr, exp_err);
			if (!write) check_value("prdata", prdata, exp_rdata);
			@(posedge clk_in);
			#1;
			apb_req = '0;
		end
	endtask

	task automatic send_sample(input int sample, input logic lock, input int exp);
		int                 gap;
		int                 edges;
		logic [31:0]        junk;
		logic signed [31:0] got;
		begin
			gap = next_random() % 6;	// idle 0..5 cycles
			repeat (gap) @(posedge clk_in);
			@(posedge clk_in);
			#1;
			check_value("sample_ready", sample_ready, 1'b1);
			check_value("out_valid", out_valid, 1'b0);
			sample_valid = 1'b1;
			sample_data  = sample[17:0];
			lock_en      = lock;
			@(posedge clk_in);	// capture edge
			#1;
			junk         = next_random();
			sample_data  = junk[17:0];	// busy offer, must be dropped
			lock_en      = junk[20];
			check_value("sample_ready", sample_ready, 1'b0);
			edges = 0;
			while (out_valid !== 1'b1 && edges < COMP_LATENCY + 5) begin
				@(posedge clk_in);
				#1;
				edges++;
				sample_valid = 1'b0;
				check_value("sample_ready", sample_ready, 1'b0);	// busy until done
			end
			checks++;
			assert (out_valid === 1'b1) else begin
				$display("out_valid never rose within %0d edges of the capture", edges);
				errors++;
			end
			if (out_valid === 1'b1) begin
				checks++;
				assert (edges == COMP_LATENCY) else begin
					$display("out_valid rose %0d edges after capture instead of %0d",
						edges, COMP_LATENCY);
					errors++;
				end
				got = out_data;	// sign extend
				check_value("out_data", got, exp);
				#7;
				got = out_data;	// late in the valid cycle
				check_value("out_data", got, exp);
				@(posedge clk_in);
				#1;
				check_value("out_valid", out_valid, 1'b0);	// single cycle
				check_value("sample_ready", sample_ready, 1'b0);
				@(posedge clk_in);
				#1;
				check_value("sample_ready", sample_ready, 1'b1);	// back in idle
			end
		end
	endtask

	////////////////////
	// stimulus
	////////////////////

	initial begin : main_flow
		int              fd;
		int              code;
		logic [8*128-1:0] line;
		logic [7:0]      op;
		logic [31:0]     addr;
		logic [31:0]     data;
		int              v1;
		int              v2;
		int              v3;
		logic            in_test;
		reset_in     = 1'b1;
		apb_req      = '0;
		sample_data  = '0;
		sample_valid = 1'b0;
		lock_en      = 1'b0;
		rng_state    = 32'd31;	// seed
		checks       = 0;
		errors       = 0;
		tests        = 0;
		in_test      = 1'b0;
		test_name    = "none";
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %0s", STIM_FILE);
			$display("TESTS FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0) line_count++;
			end
			$fclose(fd);
			fd = $fopen(STIM_FILE, "r");	// second pass runs the operations
			repeat (RESET_CYCLES) @(posedge clk_in);
			#1;
			reset_in = 1'b0;
			while (!$feof(fd)) begin
				line = '0;
				code = $fgets(line, fd);
				if (code > 0) code = $sscanf(line, " %c", op);
				if (code == 1 && op != "#") begin
					case (op)
						"T": begin
							if (in_test) finish_test();
							code        = $sscanf(line, " %c %s", op, test_name);
							in_test     = 1'b1;
							test_checks = checks;
							test_errors = errors;
						end
						"W": begin
							code = $sscanf(line, " %c %h %h", op, addr, data);
							apb_transfer(1'b1, addr[4:0], data, '0, !addr_mapped(addr[4:0]));
							if (addr[4:0] == ADDR_CTRL) begin
								// only the enable bit is stored
								apb_transfer(1'b0, ADDR_CTRL, '0, {31'd0, data[0]}, 1'b0);
							end
						end
						"R": begin
							code = $sscanf(line, " %c %h %h %d", op, addr, data, v1);
							apb_transfer(1'b0, addr[4:0], '0, data, v1[0]);
						end
						"S": begin
							code = $sscanf(line, " %c %d %d %d", op, v1, v2, v3);
							send_sample(v1, v2[0], v3);
						end
						default: begin
							$display("unknown operation in stimulus line: %0s", line);
							errors++;
						end
					endcase
				end
			end
			if (in_test) finish_test();
			$fclose(fd);
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

	initial begin : watchdog
		wait (reset_in === 1'b0);	// line count complete by now
		repeat (RESET_CYCLES + line_count * (COMP_LATENCY + 10)) @(posedge clk_in);
		$display("watchdog expired, stimulus did not complete in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/opp_stimulus.txt
# W addr data | R addr expected_data expected_err | S sample lock expected_out | T test_name
# addresses and register data in hex, samples and outputs in signed decimal
T reset_defaults
S 500 0 19660
S 0 1 19660
T apb_access
R 00 6666 0
W 00 7000
R 00 7000 0
W 04 0800
R 04 800 0
W 08 c000
R 08 ffffc000 0
W 0c 3
R 0c 3 0
R 18 0 1
R 14 0 1
T update_gating
W 14 1
S 10000 1 22160
W 08 5000
W 10 1
W 14 0
S 0 1 20480
T gain_accumulation
S 1000 1 21230
S 2001 1 22730
S -1500 1 21605
S 100000 1 28672
S -100000 1 2048
T bound_clamping
W 00 1000
W 04 f000
W 08 0
W 0c 2
W 14 0
S 3000 1 1500
S 6000 1 4096
S -8000 1 96
S -16000 1 -4096
S -131072 1 -4096
S 5 1 -4094
W 00 0400
W 04 0c00
W 14 0
S 100 1 3072
S 0 0 3072
T timing
W 00 6666
W 04 1999
W 14 0
S 20000 1 10000
S 7 1 10003
S -20000 1 6553

//--- flist.f
logic/opp_data_pkg.sv
logic/opp_regs_pkg.sv
logic/opp_apb_regs.sv
logic/opp_sequencer.sv
logic/opp_latency_timer.sv
logic/opp_accumulator.sv
logic/opp_output_clamp.sv
logic/output_preprocessor.sv
test/opp_tb.sv

//--- Bender.yml
package:
  name: output_preprocessor

sources:
  - logic/opp_data_pkg.sv
  - logic/opp_regs_pkg.sv
  - logic/opp_apb_regs.sv
  - logic/opp_sequencer.sv
  - logic/opp_latency_timer.sv
  - logic/opp_accumulator.sv
  - logic/opp_output_clamp.sv
  - logic/output_preprocessor.sv
  - target: test
    files:
      - test/opp_tb.sv
